//--- src/sinc_cfg_pkg.sv
package sinc_cfg_pkg;

	// ########################################################################
	// widths
	// ########################################################################

	localparam int acc_width   = 37;    // 3 * log2(4096) + sign
	localparam int count_width = 13;    // holds 4096
	localparam int code_width  = 4;

	typedef logic [code_width-1:0] rate_code_t;    // rate = 32 << code

	// ########################################################################
	// rate codes
	// ########################################################################

	localparam logic [count_width-1:0] base_rate = 13'd32;    // rate at code 0
	localparam rate_code_t max_rate_code         = 4'd7;     // 4096
	localparam rate_code_t default_rate_code     = 4'd3;     // 256, also fallback

	// decimation setting as loaded by the config strobe
	typedef struct packed {
		rate_code_t rate_code;
		logic [1:0] chan_enable;    // one bit per channel
	} sinc_cfg_t;

	// codes above 7 decimate by 256
	function automatic rate_code_t effective_code(input rate_code_t code);
		return (code > max_rate_code) ? default_rate_code : code;
	endfunction

endpackage

//--- src/sinc_sample_pkg.sv
package sinc_sample_pkg;

	// ########################################################################
	// output sample
	// ########################################################################

	localparam int num_channels = 2;
	localparam int sample_width = 16;    // unsigned, saturated

	typedef struct packed {
		logic [sample_width-1:0] value;      // filtered word
		logic                    channel;    // source channel index
	} sample_t;

endpackage

//--- src/decimation_timer.sv
`timescale 1ns/1ns

module decimation_timer (
	input  logic                     mclk1,
	input  logic                     reset,
	input  logic                     restart,
	input  sinc_cfg_pkg::rate_code_t rate_code,
	output logic                     word_strobe
);

	sinc_cfg_pkg::rate_code_t             code;        // after invalid-code fallback
	logic [sinc_cfg_pkg::count_width-1:0] terminal;    // rate - 1
	logic [sinc_cfg_pkg::count_width-1:0] count;

	assign code     = sinc_cfg_pkg::effective_code(rate_code);
	assign terminal = (sinc_cfg_pkg::base_rate << code) - 1'b1;

	// ########################################################################
	// word counter, wraps at rate - 1
	// ########################################################################

	always_ff @(posedge mclk1 or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (restart) begin
			count <= '0;    // config load realigns words
		end else if (count == terminal) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// one cycle per word, combs take it on the closing edge
	assign word_strobe = (count == terminal);

endmodule

//--- src/sinc3_integrator.sv
`timescale 1ns/1ns

module sinc3_integrator (
	input  logic                            mclk1,
	input  logic                            reset,
	input  logic                            clear,
	input  logic                            mdata,
	output logic [sinc_cfg_pkg::acc_width-1:0] acc3
);

	logic [sinc_cfg_pkg::acc_width-1:0] ip_data;    // modulator bit as 0 or 1
	logic [sinc_cfg_pkg::acc_width-1:0] acc1;
	logic [sinc_cfg_pkg::acc_width-1:0] acc2;

	assign ip_data = {{(sinc_cfg_pkg::acc_width-1){1'b0}}, mdata};

	// ########################################################################
	// three integrators at modulator rate
	// ########################################################################

	// sums wrap modulo 2^37, the combs undo the wrap
	always_ff @(posedge mclk1 or posedge reset) begin
		if (reset) begin
			acc1 <= '0;
			acc2 <= '0;
			acc3 <= '0;
		end else if (clear) begin
			acc1 <= '0;
			acc2 <= '0;
			acc3 <= '0;
		end else begin
			acc1 <= acc1 + ip_data;
			acc2 <= acc2 + acc1;    // previous acc1, one stage per cycle
			acc3 <= acc3 + acc2;
		end
	end

endmodule

//--- src/sinc3_comb.sv
`timescale 1ns/1ns

module sinc3_comb (
	input  logic                               mclk1,
	input  logic                               reset,
	input  logic                               clear,
	input  logic                               word_strobe,
	input  logic [sinc_cfg_pkg::acc_width-1:0] acc3,
	output logic [sinc_cfg_pkg::acc_width-1:0] diff3,
	output logic                               diff_valid
);

	logic [sinc_cfg_pkg::acc_width-1:0] acc3_d;     // integrator at last word
	logic [sinc_cfg_pkg::acc_width-1:0] diff1_d;
	logic [sinc_cfg_pkg::acc_width-1:0] diff2_d;
	logic [sinc_cfg_pkg::acc_width-1:0] diff1;
	logic [sinc_cfg_pkg::acc_width-1:0] diff2;
	logic [sinc_cfg_pkg::acc_width-1:0] diff3_next;

	// all three differences settle within the strobe cycle
	assign diff1      = acc3 - acc3_d;
	assign diff2      = diff1 - diff1_d;
	assign diff3_next = diff2 - diff2_d;

	// ########################################################################
	// differentiators at word rate
	// ########################################################################

	always_ff @(posedge mclk1 or posedge reset) begin
		if (reset) begin
			acc3_d  <= '0;
			diff1_d <= '0;
			diff2_d <= '0;
			diff3   <= '0;
		end else if (clear) begin
			acc3_d  <= '0;
			diff1_d <= '0;
			diff2_d <= '0;
			diff3   <= '0;
		end else if (word_strobe) begin
			acc3_d  <= acc3;
			diff1_d <= diff1;
			diff2_d <= diff2;
			diff3   <= diff3_next;
		end
	end

	// marks the cycle in which diff3 holds the new word
	always_ff @(posedge mclk1 or posedge reset) begin
		if (reset) begin
			diff_valid <= 1'b0;
		end else if (clear) begin
			diff_valid <= 1'b0;
		end else begin
			diff_valid <= word_strobe;
		end
	end

endmodule

//--- src/output_scaler.sv
`timescale 1ns/1ns

module output_scaler (
	input  logic                                     mclk1,
	input  logic                                     reset,
	input  logic                                     clear,
	input  sinc_cfg_pkg::rate_code_t                 rate_code,
	input  logic [sinc_cfg_pkg::acc_width-1:0]       diff3,
	input  logic                                     diff_valid,
	output logic [sinc_sample_pkg::sample_width-1:0] value,
	output logic                                     value_valid
);

	sinc_cfg_pkg::rate_code_t             code;
	logic [4:0]                           shift;         // 3 * code
	logic [sinc_cfg_pkg::acc_width:0]     window;        // diff3 with extra lsb
	logic                                 full_scale;

	assign code = sinc_cfg_pkg::effective_code(rate_code);

	// ########################################################################
	// bit selection
	// ########################################################################

	// full scale of a sinc3 at rate 2^(5+c) is 2^(15+3c), so the 16 bits
	// under it start at bit 3c-1; rate 32 starts at -1, giving a left shift
	assign shift  = 5'(3 * code);
	assign window = {diff3, 1'b0} >> shift;

	// exactly rate cubed
	assign full_scale = (window[sinc_sample_pkg::sample_width:0] ==
		{1'b1, {sinc_sample_pkg::sample_width{1'b0}}});

	// ########################################################################
	// output registers
	// ########################################################################

	always_ff @(posedge mclk1 or posedge reset) begin
		if (reset) begin
			value <= '0;
		end else if (clear) begin
			value <= '0;
		end else if (diff_valid) begin
			value <= full_scale ? '1 : window[sinc_sample_pkg::sample_width-1:0];    // saturate
		end
	end

	always_ff @(posedge mclk1 or posedge reset) begin
		if (reset) begin
			value_valid <= 1'b0;
		end else if (clear) begin
			value_valid <= 1'b0;
		end else begin
			value_valid <= diff_valid;    // same edge as value
		end
	end

endmodule

//--- src/sinc3_channel.sv
`timescale 1ns/1ns

module sinc3_channel #(
	parameter int unsigned channel_index = 0    // 0 or 1
) (
	input  logic                     mclk1,
	input  logic                     reset,
	input  logic                     clear,
	input  logic                     mdata,
	input  sinc_cfg_pkg::rate_code_t rate_code,
	input  logic                     word_strobe,
	output sinc_sample_pkg::sample_t sample,
	output logic                     sample_valid
);

	logic [sinc_cfg_pkg::acc_width-1:0]       acc3;
	logic [sinc_cfg_pkg::acc_width-1:0]       diff3;
	logic                                     diff_valid;
	logic [sinc_sample_pkg::sample_width-1:0] value;

	// ########################################################################
	// integrate, decimate, scale
	// ########################################################################

	sinc3_integrator u_integrator (
		.mclk1 (mclk1),
		.reset (reset),
		.clear (clear),
		.mdata (mdata),
		.acc3  (acc3)
	);

	sinc3_comb u_comb (
		.mclk1       (mclk1),
		.reset       (reset),
		.clear       (clear),
		.word_strobe (word_strobe),
		.acc3        (acc3),
		.diff3       (diff3),
		.diff_valid  (diff_valid)
	);

	output_scaler u_scaler (
		.mclk1       (mclk1),
		.reset       (reset),
		.clear       (clear),
		.rate_code   (rate_code),
		.diff3       (diff3),
		.diff_valid  (diff_valid),
		.value       (value),
		.value_valid (sample_valid)
	);

	assign sample.value   = value;
	assign sample.channel = 1'(channel_index);    // tag for the consumer

endmodule

//--- src/sd_filter_top.sv
`timescale 1ns/1ns

module sd_filter_top (
	input  logic                                                    mclk1,
	input  logic                                                    reset,
	input  logic [sinc_sample_pkg::num_channels-1:0]                mdata,
	input  logic                                                    cfg_strobe,
	input  sinc_cfg_pkg::sinc_cfg_t                                 cfg,
	output sinc_sample_pkg::sample_t [sinc_sample_pkg::num_channels-1:0] sample,
	output logic [sinc_sample_pkg::num_channels-1:0]                sample_valid
);

	sinc_cfg_pkg::sinc_cfg_t                  cfg_reg;
	logic                                     word_strobe;
	logic [sinc_sample_pkg::num_channels-1:0] chan_valid;    // before enable gating

	// ########################################################################
	// configuration register
	// ########################################################################

	always_ff @(posedge mclk1 or posedge reset) begin
		if (reset) begin
			cfg_reg.rate_code   <= sinc_cfg_pkg::default_rate_code;
			cfg_reg.chan_enable <= '1;    // both channels on
		end else if (cfg_strobe) begin
			cfg_reg <= cfg;
		end
	end

	// ########################################################################
	// shared word timer
	// ########################################################################

	// the load edge also restarts the count and clears every filter stage
	decimation_timer u_timer (
		.mclk1       (mclk1),
		.reset       (reset),
		.restart     (cfg_strobe),
		.rate_code   (cfg_reg.rate_code),
		.word_strobe (word_strobe)
	);

	// ########################################################################
	// filter channels
	// ########################################################################

	for (genvar i = 0; i < sinc_sample_pkg::num_channels; i++) begin : g_chan
		sinc3_channel #(
			.channel_index (i)
		) u_channel (
			.mclk1        (mclk1),
			.reset        (reset),
			.clear        (cfg_strobe),
			.mdata        (mdata[i]),
			.rate_code    (cfg_reg.rate_code),
			.word_strobe  (word_strobe),
			.sample       (sample[i]),
			.sample_valid (chan_valid[i])
		);
	end

	// disabled channels keep filtering, only the pulse is masked
	assign sample_valid = chan_valid & cfg_reg.chan_enable;

endmodule

//--- verification/sinc3_model.svh
`ifndef SINC3_MODEL_SVH
`define SINC3_MODEL_SVH

// ############################################################################
// behavioral sinc3, stepped once per rising mclk1
// ############################################################################

typedef logic [sinc_cfg_pkg::acc_width-1:0] acc_t;

acc_t        integ1 [2];
acc_t        integ2 [2];
acc_t        integ3 [2];
acc_t        last_integ [2];     // integrator value at previous word
acc_t        last_diff1 [2];
acc_t        last_diff2 [2];
acc_t        comb_out [2];
logic [15:0] model_value [2];    // expected word while out_fired is high
logic [1:0]  model_enable;
logic        comb_fired;         // word boundary on the last edge
logic        out_fired;          // scaled word shown after this edge
int          model_rate;
int          model_count;        // cycles since load, wraps at rate
int          word_number;        // words since load or reset

function automatic int rate_for_code(input logic [3:0] code);
	if (code > 4'd7) begin
		return 256;    // invalid codes
	end
	return 32 << code;
endfunction

// full scale is rate cubed, the 16 bits below it form the word
function automatic logic [15:0] scale_word(input acc_t diff, input int rate);
	longint rate_l;
	longint full;
	longint scaled;
	rate_l = rate;
	full   = rate_l * rate_l * rate_l;
	if (longint'(diff) >= full) begin
		return 16'hffff;    // saturate
	end
	scaled = (longint'(diff) << 16) / full;
	return scaled[15:0];
endfunction

task automatic model_step(input logic rst, input logic load,
		input sinc_cfg_pkg::sinc_cfg_t new_cfg, input logic [1:0] bits);
	acc_t d1;
	acc_t d2;
	if (rst || load) begin
		for (int ch = 0; ch < 2; ch++) begin
			integ1[ch]     = '0;
			integ2[ch]     = '0;
			integ3[ch]     = '0;
			last_integ[ch] = '0;
			last_diff1[ch] = '0;
			last_diff2[ch] = '0;
			comb_out[ch]   = '0;
		end
		comb_fired  = 1'b0;
		out_fired   = 1'b0;
		model_count = 0;
		word_number = 0;
		if (rst) begin
			model_rate   = rate_for_code(sinc_cfg_pkg::default_rate_code);
			model_enable = 2'b11;
		end else begin
			model_rate   = rate_for_code(new_cfg.rate_code);
			model_enable = new_cfg.chan_enable;
		end
	end else begin
		out_fired  = comb_fired;    // scaler one edge behind the combs
		comb_fired = (model_count == model_rate - 1);
		if (out_fired) begin
			word_number++;
		end
		for (int ch = 0; ch < 2; ch++) begin
			if (out_fired) begin
				model_value[ch] = scale_word(comb_out[ch], model_rate);
			end
			if (comb_fired) begin
				d1             = integ3[ch] - last_integ[ch];
				d2             = d1 - last_diff1[ch];
				comb_out[ch]   = d2 - last_diff2[ch];
				last_integ[ch] = integ3[ch];
				last_diff1[ch] = d1;
				last_diff2[ch] = d2;
			end
			integ3[ch] = integ3[ch] + integ2[ch];    // old values feed forward
			integ2[ch] = integ2[ch] + integ1[ch];
			integ1[ch] = integ1[ch] + acc_t'(bits[ch]);
		end
		model_count = comb_fired ? 0 : model_count + 1;
	end
endtask

`endif

//--- verification/sd_filter_tb.sv
`timescale 1ns/1ns

module sd_filter_tb;

	localparam logic [1:0] pat_zero = 2'd0;
	localparam logic [1:0] pat_one  = 2'd1;
	localparam logic [1:0] pat_alt  = 2'd2;
	localparam logic [1:0] pat_rand = 2'd3;    // ones density 1/4
	localparam int         num_rows = 16;

	typedef struct packed {
		logic       load;         // 0 keeps the reset configuration
		logic [3:0] rate_code;
		logic [1:0] enable;
		logic [1:0] kind0;
		logic [1:0] kind1;
		int         samples;      // checked samples after settling
	} row_t;

	logic                                                    mclk1;
	logic                                                    reset;
	logic [sinc_sample_pkg::num_channels-1:0]                mdata;
	logic                                                    cfg_strobe;
	sinc_cfg_pkg::sinc_cfg_t                                 cfg;
	sinc_sample_pkg::sample_t [sinc_sample_pkg::num_channels-1:0] sample;
	logic [sinc_sample_pkg::num_channels-1:0]                sample_valid;

	logic [1:0] cur_kind [2];
	logic       alt_bit;
	int         cycle_count;
	int         cycle_limit;
	int         checked [2];
	int         last_valid [2];    // cycle of previous pulse, -1 after load

	row_t stim_table [num_rows] = '{
		'{1'b0, 4'd3,  2'b11, pat_rand, pat_rand, 3},    // reset configuration
		'{1'b1, 4'd3,  2'b11, pat_one,  pat_zero, 4},
		'{1'b1, 4'd1,  2'b11, pat_alt,  pat_alt,  4},
		'{1'b1, 4'd3,  2'b11, pat_alt,  pat_rand, 4},
		'{1'b1, 4'd7,  2'b11, pat_alt,  pat_zero, 3},
		'{1'b1, 4'd0,  2'b11, pat_rand, pat_rand, 6},    // left shift
		'{1'b1, 4'd1,  2'b11, pat_rand, pat_rand, 5},
		'{1'b1, 4'd2,  2'b11, pat_rand, pat_rand, 5},
		'{1'b1, 4'd3,  2'b11, pat_rand, pat_rand, 4},
		'{1'b1, 4'd4,  2'b11, pat_rand, pat_rand, 4},
		'{1'b1, 4'd5,  2'b11, pat_rand, pat_rand, 3},
		'{1'b1, 4'd6,  2'b11, pat_rand, pat_rand, 3},
		'{1'b1, 4'd7,  2'b11, pat_rand, pat_rand, 3},
		'{1'b1, 4'd12, 2'b11, pat_rand, pat_rand, 4},    // falls back to 256
		'{1'b1, 4'd2,  2'b01, pat_rand, pat_rand, 4},    // channel 1 masked
		'{1'b1, 4'd2,  2'b11, pat_rand, pat_rand, 4}
	};

	`include "sinc3_model.svh"

	sd_filter_top UUT (
		.mclk1        (mclk1),
		.reset        (reset),
		.mdata        (mdata),
		.cfg_strobe   (cfg_strobe),
		.cfg          (cfg),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	initial begin
		mclk1 = 1'b0;
		forever #2 mclk1 = ~mclk1;
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge mclk1);
			cycle_count++;
			if (cycle_limit > 0 && cycle_count > cycle_limit) begin
				$display("timeout: run still going after %0d cycles", cycle_limit);
				$display("TEST FAIL");
				$fatal(1, "timeout");
			end
		end
	end

	// ########################################################################
	// reporting and checks
	// ########################################################################

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		$display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
		$display("TEST FAIL");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic report_error(input string what);
		$display("error at %0t ns: %s", $time, what);
		$display("TEST FAIL");
		$fatal(1, "%s", what);
	endtask

	// steady state of the fixed patterns
	function automatic logic [15:0] fixed_value(input logic [1:0] kind_sel);
		case (kind_sel)
			pat_one: return 16'hffff;    // full scale saturates
			pat_alt: return 16'h8000;    // nyquist tone cancels in sinc3
			default: return 16'h0000;
		endcase
	endfunction

	task automatic check_outputs();
		logic expect_valid;
		for (int ch = 0; ch < 2; ch++) begin
			expect_valid = out_fired & model_enable[ch];
			assert (sample_valid[ch] === expect_valid) else
				report_mismatch($sformatf("sample_valid[%0d]", ch),
					32'(sample_valid[ch]), 32'(expect_valid));
			if (expect_valid) begin
				assert (sample[ch].channel === ch[0]) else
					report_mismatch($sformatf("sample[%0d].channel", ch),
						32'(sample[ch].channel), 32'(ch[0]));
				if (last_valid[ch] >= 0) begin
					assert (cycle_count - last_valid[ch] == model_rate) else
						report_error($sformatf("channel %0d pulses %0d cycles apart, rate %0d",
							ch, cycle_count - last_valid[ch], model_rate));
				end
				last_valid[ch] = cycle_count;
				if (word_number >= 3) begin    // first two words are settling
					assert (sample[ch].value === model_value[ch]) else
						report_mismatch($sformatf("sample[%0d].value", ch),
							32'(sample[ch].value), 32'(model_value[ch]));
					checked[ch]++;
				end
				// step response needs one more word to clear the start-up taps
				if (word_number >= 4 && cur_kind[ch] != pat_rand) begin
					assert (sample[ch].value === fixed_value(cur_kind[ch])) else
						report_mismatch($sformatf("sample[%0d].value", ch),
							32'(sample[ch].value), 32'(fixed_value(cur_kind[ch])));
				end
			end
		end
	endtask

	// ########################################################################
	// stimulus
	// ########################################################################

	function automatic logic next_bit(input logic [1:0] kind_sel);
		case (kind_sel)
			pat_zero: return 1'b0;
			pat_one:  return 1'b1;
			pat_alt:  return alt_bit;
			default:  return ($urandom % 4 == 0);
		endcase
	endfunction

	task automatic drive_bits();
		alt_bit  = ~alt_bit;
		mdata[0] = next_bit(cur_kind[0]);
		mdata[1] = next_bit(cur_kind[1]);
	endtask

	// model sees the inputs of the closing cycle, outputs checked after the edge
	task step_cycle();
		@(posedge mclk1);
		model_step(reset, cfg_strobe, cfg, mdata);
		#1;
		check_outputs();
	endtask

	task apply_row(input row_t row);
		int rate;
		rate        = rate_for_code(row.rate_code);
		cur_kind[0] = row.kind0;
		cur_kind[1] = row.kind1;
		for (int ch = 0; ch < 2; ch++) begin
			checked[ch]    = 0;
			last_valid[ch] = -1;
		end
		if (row.load) begin
			cfg_strobe      = 1'b1;
			cfg.rate_code   = row.rate_code;
			cfg.chan_enable = row.enable;
			drive_bits();
			step_cycle();
			cfg_strobe = 1'b0;
		end
		drive_bits();
		repeat ((row.samples + 2) * rate + 2) begin
			step_cycle();
			drive_bits();
		end
		for (int ch = 0; ch < 2; ch++) begin
			assert (checked[ch] == (row.enable[ch] ? row.samples : 0)) else
				report_error($sformatf("channel %0d gave %0d settled samples in row with %0d",
					ch, checked[ch], row.samples));
		end
	endtask

	initial begin
		void'($urandom(49));
		reset       = 1'b1;
		cfg_strobe  = 1'b0;
		cfg         = '0;
		mdata       = '0;
		alt_bit     = 1'b0;
		cur_kind[0] = pat_zero;
		cur_kind[1] = pat_zero;
		cycle_limit = 100;
		for (int r = 0; r < num_rows; r++) begin
			cycle_limit += rate_for_code(stim_table[r].rate_code) * (stim_table[r].samples + 3);
		end
		for (int ch = 0; ch < 2; ch++) begin
			checked[ch]    = 0;
			last_valid[ch] = -1;
		end
		repeat (3) step_cycle();
		reset = 1'b0;
		for (int r = 0; r < num_rows; r++) begin
			apply_row(stim_table[r]);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- sd_filter.f
+incdir+verification
src/sinc_cfg_pkg.sv
src/sinc_sample_pkg.sv
src/decimation_timer.sv
src/sinc3_integrator.sv
src/sinc3_comb.sv
src/output_scaler.sv
src/sinc3_channel.sv
src/sd_filter_top.sv
verification/sd_filter_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the sd_filter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module sd_filter_tb \
	--Mdir "$build_dir" -o sd_filter_sim \
	-f sd_filter.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/sd_filter_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST PASS" "$log_file"; then
	echo "result: pass"
	exit 0
fi
echo "result: fail"
exit 1
